// File: mem_bus_pkg.sv
package mem_bus_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;

  // bytes per bus word, also the fetch step.
  localparam int word_bytes = data_width / 8;

  typedef logic [addr_width-1 : 0] addr_t;
  typedef logic [data_width-1 : 0] data_t;
  typedef logic [word_bytes-1 : 0] strb_t;

  localparam strb_t strb_none = '0; // read.

endpackage

// File: lsu_pkg.sv
package lsu_pkg;

  typedef enum logic [2 : 0] {
    op_lb,
    op_lh,
    op_lw,
    op_lbu,
    op_lhu,
    op_sb,
    op_sh,
    op_sw
  } lsu_op_t;

  function automatic logic op_is_store(lsu_op_t op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

  // access width in bytes.
  function automatic logic [2 : 0] op_size_bytes(lsu_op_t op);
    case (op)
      op_lb, op_lbu, op_sb: return 3'd1;
      op_lh, op_lhu, op_sh: return 3'd2;
      default:              return 3'd4;
    endcase
  endfunction

  function automatic logic op_is_signed(lsu_op_t op);
    return op inside {op_lb, op_lh};
  endfunction

endpackage

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter mem_bus_pkg::addr_t reset_pc = '0
)
(
  input  logic               clock,
  input  logic               rst_n,
  input  logic               fetch_enable,
  input  logic               redirect,
  input  mem_bus_pkg::addr_t redirect_addr,
  output logic               f_req,
  output mem_bus_pkg::addr_t f_addr,
  input  logic               f_gnt_ready,
  input  mem_bus_pkg::data_t mem_rdata,
  output logic               instr_valid,
  output mem_bus_pkg::data_t instr,
  output mem_bus_pkg::addr_t instr_addr
);
  import mem_bus_pkg::*;

  addr_t pc;
  addr_t next_pc;
  logic  drop;
  logic  deliver;

  assign next_pc = redirect ? redirect_addr : pc;

  // a redirect in the ready cycle also kills that word.
  assign deliver = f_req && f_gnt_ready && !drop && !redirect;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= reset_pc;
      f_addr      <= reset_pc;
      f_req       <= 1'b0;
      drop        <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= deliver; // one cycle after ready.

      if (redirect) begin
        pc <= redirect_addr;
      end else if (deliver) begin
        pc <= f_addr + addr_t'(word_bytes);
      end

      if (f_req) begin
        if (f_gnt_ready) begin
          f_req <= 1'b0;
          drop  <= 1'b0;
        end else if (redirect) begin
          drop <= 1'b1; // let it finish, throw the data away.
        end
      end else if (fetch_enable) begin
        f_req  <= 1'b1;
        f_addr <= next_pc;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (deliver) begin
      instr      <= mem_rdata;
      instr_addr <= f_addr;
    end
  end

endmodule

// File: lsu.sv
`timescale 1ns/1ps

module lsu
(
  input  logic               clock,
  input  logic               rst_n,
  input  logic               lsu_valid,
  input  lsu_pkg::lsu_op_t   lsu_op,
  input  mem_bus_pkg::addr_t lsu_addr,
  input  mem_bus_pkg::data_t lsu_wdata,
  output logic               busy,
  output logic               lsu_done,
  output logic               misaligned,
  output mem_bus_pkg::data_t lsu_rdata,
  output logic               d_req,
  output mem_bus_pkg::addr_t d_addr,
  output mem_bus_pkg::data_t d_wdata,
  output mem_bus_pkg::strb_t d_wstrb,
  input  logic               d_gnt_ready,
  input  mem_bus_pkg::data_t mem_rdata
);
  import mem_bus_pkg::*;
  import lsu_pkg::*;

  logic          start;
  logic [2 : 0]  size;
  logic          bad_align;
  logic [1 : 0]  ld_off;
  logic [2 : 0]  ld_size;
  logic          ld_signed;
  logic          ld_store;
  data_t         lane;
  data_t         ld_value;

  assign start = lsu_valid && !busy;
  assign size  = op_size_bytes(lsu_op);
  assign busy  = d_req; // one access in flight.

  assign bad_align = (size == 3'd2 && lsu_addr[0]) ||
                     (size == 3'd4 && lsu_addr[1 : 0] != 2'b00);

  // addressed lane down to bit 0.
  assign lane = mem_rdata >> {ld_off, 3'b000};

  always_comb begin
    case (ld_size)
      3'd1:    ld_value = ld_signed ? {{24{lane[7]}}, lane[7 : 0]} : {24'b0, lane[7 : 0]};
      3'd2:    ld_value = ld_signed ? {{16{lane[15]}}, lane[15 : 0]} : {16'b0, lane[15 : 0]};
      default: ld_value = lane;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      d_req      <= 1'b0;
      lsu_done   <= 1'b0;
      misaligned <= 1'b0;
    end else begin
      lsu_done   <= 1'b0;
      misaligned <= 1'b0;
      if (start && bad_align) begin
        lsu_done   <= 1'b1; // no bus transfer.
        misaligned <= 1'b1;
      end else if (start) begin
        d_req <= 1'b1;
      end else if (d_req && d_gnt_ready) begin
        d_req    <= 1'b0;
        lsu_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      d_addr    <= {lsu_addr[31 : 2], 2'b00};
      ld_off    <= lsu_addr[1 : 0];
      ld_size   <= size;
      ld_signed <= op_is_signed(lsu_op);
      ld_store  <= op_is_store(lsu_op);
      case (size)
        3'd1:    d_wdata <= {4{lsu_wdata[7 : 0]}};
        3'd2:    d_wdata <= {2{lsu_wdata[15 : 0]}};
        default: d_wdata <= lsu_wdata;
      endcase
      if (!op_is_store(lsu_op)) begin
        d_wstrb <= strb_none;
      end else begin
        case (size)
          3'd1:    d_wstrb <= strb_t'(4'b0001) << lsu_addr[1 : 0];
          3'd2:    d_wstrb <= strb_t'(4'b0011) << lsu_addr[1 : 0];
          default: d_wstrb <= '1;
        endcase
      end
    end

    if (start && bad_align) begin
      lsu_rdata <= '0;
    end else if (d_req && d_gnt_ready) begin
      lsu_rdata <= ld_store ? '0 : ld_value;
    end
  end

  // the issuer waits for lsu_done before the next op.
  a_no_valid_busy: assert property (@(posedge clock) disable iff (!rst_n)
    !(lsu_valid && busy))
    else $error("lsu_valid raised while busy");

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
  parameter logic data_first = 1'b1
)
(
  input  logic               clock,
  input  logic               rst_n,
  input  logic               f_req,
  input  mem_bus_pkg::addr_t f_addr,
  output logic               f_gnt_ready,
  input  logic               d_req,
  input  mem_bus_pkg::addr_t d_addr,
  input  mem_bus_pkg::data_t d_wdata,
  input  mem_bus_pkg::strb_t d_wstrb,
  output logic               d_gnt_ready,
  output logic               mem_valid,
  output logic               mem_instr,
  output mem_bus_pkg::addr_t mem_addr,
  output mem_bus_pkg::data_t mem_wdata,
  output mem_bus_pkg::strb_t mem_wstrb,
  input  logic               mem_ready
);
  import mem_bus_pkg::*;

  logic locked;
  logic owner_data;
  logic sel_data;

  // locked owner keeps its req high until ready.
  always_comb begin
    if (locked) begin
      sel_data = owner_data;
    end else begin
      sel_data = d_req && (data_first || !f_req);
    end
  end

  assign mem_valid = sel_data ? d_req : f_req;
  assign mem_instr = mem_valid && !sel_data;
  assign mem_addr  = sel_data ? d_addr : f_addr;
  assign mem_wdata = sel_data ? d_wdata : '0;
  assign mem_wstrb = sel_data ? d_wstrb : strb_none; // fetch is a read.

  assign f_gnt_ready = mem_valid && !sel_data && mem_ready;
  assign d_gnt_ready = mem_valid && sel_data && mem_ready;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      locked     <= 1'b0;
      owner_data <= 1'b0;
    end else begin
      locked <= mem_valid && !mem_ready;
      if (mem_valid && !locked) begin
        owner_data <= sel_data;
      end
    end
  end

  // bus rule toward the memory.
  a_hold: assert property (@(posedge clock) disable iff (!rst_n)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wstrb))
    else $error("bus request changed before ready");

  // a waiting peer keeps its request.
  a_f_wait: assert property (@(posedge clock) disable iff (!rst_n)
    f_req && !f_gnt_ready |=> f_req && $stable(f_addr))
    else $error("fetch request changed before its ready");

  a_d_wait: assert property (@(posedge clock) disable iff (!rst_n)
    d_req && !d_gnt_ready |=>
      d_req && $stable(d_addr) && $stable(d_wdata) && $stable(d_wstrb))
    else $error("data request changed before its ready");

endmodule

// File: cpu_memory.sv
`timescale 1ns/1ps

module cpu_memory #(
  parameter mem_bus_pkg::addr_t reset_pc   = 32'h0000_0000,
  parameter logic               data_first = 1'b1
)
(
  input  logic               clock,
  input  logic               rst_n,
  input  logic               fetch_enable,
  input  logic               redirect,
  input  mem_bus_pkg::addr_t redirect_addr,
  output logic               instr_valid,
  output mem_bus_pkg::data_t instr,
  output mem_bus_pkg::addr_t instr_addr,
  input  logic               lsu_valid,
  input  lsu_pkg::lsu_op_t   lsu_op,
  input  mem_bus_pkg::addr_t lsu_addr,
  input  mem_bus_pkg::data_t lsu_wdata,
  output logic               busy,
  output logic               lsu_done,
  output logic               misaligned,
  output mem_bus_pkg::data_t lsu_rdata,
  output logic               mem_valid,
  output logic               mem_instr,
  output mem_bus_pkg::addr_t mem_addr,
  output mem_bus_pkg::data_t mem_wdata,
  output mem_bus_pkg::strb_t mem_wstrb,
  input  mem_bus_pkg::data_t mem_rdata,
  input  logic               mem_ready
);
  import mem_bus_pkg::*;

  logic  f_req;
  addr_t f_addr;
  logic  f_gnt_ready;
  logic  d_req;
  addr_t d_addr;
  data_t d_wdata;
  strb_t d_wstrb;
  logic  d_gnt_ready;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) fetch_unit_i
  (
    .clock (clock),
    .rst_n (rst_n),
    .fetch_enable (fetch_enable),
    .redirect (redirect),
    .redirect_addr (redirect_addr),
    .f_req (f_req),
    .f_addr (f_addr),
    .f_gnt_ready (f_gnt_ready),
    .mem_rdata (mem_rdata),
    .instr_valid (instr_valid),
    .instr (instr),
    .instr_addr (instr_addr)
  );

  lsu lsu_i
  (
    .clock (clock),
    .rst_n (rst_n),
    .lsu_valid (lsu_valid),
    .lsu_op (lsu_op),
    .lsu_addr (lsu_addr),
    .lsu_wdata (lsu_wdata),
    .busy (busy),
    .lsu_done (lsu_done),
    .misaligned (misaligned),
    .lsu_rdata (lsu_rdata),
    .d_req (d_req),
    .d_addr (d_addr),
    .d_wdata (d_wdata),
    .d_wstrb (d_wstrb),
    .d_gnt_ready (d_gnt_ready),
    .mem_rdata (mem_rdata)
  );

  // read data goes straight to both peers.
  mem_arbiter #(
    .data_first (data_first)
  ) mem_arbiter_i
  (
    .clock (clock),
    .rst_n (rst_n),
    .f_req (f_req),
    .f_addr (f_addr),
    .f_gnt_ready (f_gnt_ready),
    .d_req (d_req),
    .d_addr (d_addr),
    .d_wdata (d_wdata),
    .d_wstrb (d_wstrb),
    .d_gnt_ready (d_gnt_ready),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_addr (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready)
  );

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
(
  input  logic               clock,
  input  logic               rst_n,
  input  logic               mem_valid,
  input  logic               mem_instr,
  input  mem_bus_pkg::addr_t mem_addr,
  input  mem_bus_pkg::data_t mem_wdata,
  input  mem_bus_pkg::strb_t mem_wstrb,
  output mem_bus_pkg::data_t mem_rdata,
  output logic               mem_ready
);
  import mem_bus_pkg::*;

  data_t          mem [0 : 1023];
  logic           log_instr [0 : 4095]; // one entry per completed transfer.
  addr_t          log_addr [0 : 4095];
  strb_t          log_wstrb [0 : 4095];
  int             log_count;
  logic [31 : 0]  rand_state;
  logic [31 : 0]  rand_next;
  logic [1 : 0]   delay_left;

  function automatic logic [31 : 0] xorshift32(input logic [31 : 0] x);
    logic [31 : 0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = ~(32'(i) << 2); // inverted byte address.
    end
  end

  assign rand_next = xorshift32(rand_state);
  assign mem_ready = mem_valid && delay_left == 2'd0;
  assign mem_rdata = mem[mem_addr[11 : 2]];

  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rand_state <= 32'd23;
      delay_left <= 2'd0;
      log_count  <= 0;
    end else if (mem_valid && mem_ready) begin
      for (int b = 0; b < word_bytes; b++) begin
        if (mem_wstrb[b]) begin
          mem[mem_addr[11 : 2]][8 * b +: 8] <= mem_wdata[8 * b +: 8];
        end
      end
      if (log_count < 4096) begin
        log_instr[log_count] <= mem_instr;
        log_addr[log_count]  <= mem_addr;
        log_wstrb[log_count] <= mem_wstrb;
        log_count            <= log_count + 1;
      end
      rand_state <= rand_next;
      delay_left <= rand_next[1 : 0]; // wait before the next ready.
    end else if (mem_valid) begin
      delay_left <= delay_left - 2'd1;
    end
  end

endmodule

// File: tb_cpu_memory.sv
`timescale 1ns/1ps

module tb_cpu_memory;
  import mem_bus_pkg::*;
  import lsu_pkg::*;

  localparam addr_t boot_pc    = 32'h0000_0080;
  localparam int    max_cycles = 4000;

  logic          clock = 1'b0;
  logic          rst_n;
  logic          fetch_enable;
  logic          redirect;
  addr_t         redirect_addr;
  logic          instr_valid;
  data_t         instr;
  addr_t         instr_addr;
  logic          lsu_valid;
  lsu_op_t       lsu_op;
  addr_t         lsu_addr;
  data_t         lsu_wdata;
  logic          busy;
  logic          lsu_done;
  logic          misaligned;
  data_t         lsu_rdata;
  logic          mem_valid;
  logic          mem_instr;
  addr_t         mem_addr;
  data_t         mem_wdata;
  strb_t         mem_wstrb;
  data_t         mem_rdata;
  logic          mem_ready;

  data_t         ref_mem [0 : 1023];
  addr_t         expect_pc = boot_pc;
  int            fetch_count = 0;
  int            cycles = 0;
  logic [31 : 0] rng = 32'd23;
  string         test_name = "reset";
  logic          track_bus = 1'b0;
  addr_t         xfer_addr_q [$];
  strb_t         xfer_strb_q [$];
  int            log_start;
  int            fetch_start;
  int            fetch_xfers;
  addr_t         next_fetch;

  cpu_memory #(
    .reset_pc (boot_pc),
    .data_first (1'b1)
  ) cpu_memory_i (.*);

  tb_mem_model mem_model_i (.*);

  always #4 clock = ~clock;

  function automatic logic [31 : 0] xorshift32(input logic [31 : 0] x);
    logic [31 : 0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31 : 0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // lane at the offset, upper bits from the sign or zero.
  function automatic data_t ref_load(input lsu_op_t o, input addr_t ad);
    data_t word;
    int    n;
    word = ref_mem[ad[11 : 2]] >> (8 * int'(ad[1 : 0]));
    n = int'(op_size_bytes(o));
    for (int i = 8 * n; i < 32; i++) begin
      word[i] = op_is_signed(o) ? word[8 * n - 1] : 1'b0;
    end
    return word;
  endfunction

  function automatic void ref_store(input lsu_op_t o, input addr_t ad, input data_t wd);
    int off;
    off = int'(ad[1 : 0]);
    for (int i = 0; i < int'(op_size_bytes(o)); i++) begin
      ref_mem[ad[11 : 2]][8 * (off + i) +: 8] = wd[8 * i +: 8];
    end
  endfunction

  function automatic strb_t expected_strobe(input lsu_op_t o, input addr_t ad);
    strb_t s;
    s = strb_none;
    if (op_is_store(o)) begin
      for (int i = 0; i < int'(op_size_bytes(o)); i++) begin
        s[int'(ad[1 : 0]) + i] = 1'b1;
      end
    end
    return s;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (exp !== act) begin
      abort_run($sformatf("ERROR %s, %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      abort_run($sformatf("ERROR %s, %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_strb(input string what, input strb_t exp, input strb_t act);
    if (exp !== act) begin
      abort_run($sformatf("ERROR %s, %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("ERROR %s, %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic wait_fetches(input int n);
    int target;
    target = fetch_count + n;
    while (fetch_count < target) @(posedge clock);
  endtask

  task automatic pulse_redirect(input addr_t target);
    @(posedge clock);
    #1;
    redirect      = 1'b1;
    redirect_addr = target;
    @(posedge clock);
    #1;
    redirect = 1'b0;
  endtask

  // fetch_enable is already low, so no new request follows.
  task automatic wait_bus_idle();
    @(negedge clock);
    while (mem_valid) @(negedge clock);
    @(posedge clock);
  endtask

  task automatic run_op(input string what, input lsu_op_t o, input addr_t ad, input data_t wd);
    logic  bad;
    data_t expected;
    int    waits;
    bad = (int'(ad[1 : 0]) % int'(op_size_bytes(o))) != 0;
    expected = (bad || op_is_store(o)) ? data_t'(0) : ref_load(o, ad);
    @(posedge clock);
    #1;
    lsu_valid = 1'b1;
    lsu_op    = o;
    lsu_addr  = ad;
    lsu_wdata = wd;
    @(posedge clock);
    #1;
    lsu_valid = 1'b0;
    waits = 0;
    @(negedge clock);
    while (!lsu_done) begin
      check_flag({what, " busy"}, 1'b1, busy);
      waits++;
      @(negedge clock);
    end
    check_flag({what, " misaligned"}, bad, misaligned);
    check_data({what, " rdata"}, expected, lsu_rdata);
    if (bad) begin
      check_flag({what, " done one cycle after valid"}, 1'b1, waits == 0);
    end else begin
      if (op_is_store(o)) begin
        ref_store(o, ad, wd);
      end
      if (track_bus) begin
        xfer_addr_q.push_back({ad[31 : 2], 2'b00});
        xfer_strb_q.push_back(expected_strobe(o, ad));
      end
    end
  endtask

  // sixteen words at 0x800, aligned to the access size.
  task automatic random_op();
    logic [31 : 0] x;
    lsu_op_t       o;
    addr_t         ad;
    x = rand32();
    o = lsu_op_t'(x[2 : 0]);
    ad = 32'h0000_0800 | addr_t'({x[7 : 4], 2'b00});
    if (op_size_bytes(o) == 3'd1) begin
      ad[1 : 0] = x[9 : 8];
    end else if (op_size_bytes(o) == 3'd2) begin
      ad[1] = x[9];
    end
    run_op("random op", o, ad, rand32());
  endtask

  always @(negedge clock) begin
    if (rst_n && instr_valid) begin
      check_addr("fetch address", expect_pc, instr_addr);
      check_data("fetch word", ref_mem[expect_pc[11 : 2]], instr);
      expect_pc = expect_pc + addr_t'(word_bytes);
      fetch_count++;
    end
    if (redirect) begin
      expect_pc = redirect_addr; // older words must not show up.
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= max_cycles) begin
      abort_run("timeout: the run did not finish within the cycle limit");
    end
  end

  initial begin
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = ~(32'(i) << 2);
    end
    rst_n         = 1'b0;
    fetch_enable  = 1'b0;
    redirect      = 1'b0;
    redirect_addr = '0;
    lsu_valid     = 1'b0;
    lsu_op        = op_lw;
    lsu_addr      = '0;
    lsu_wdata     = '0;
    repeat (5) @(posedge clock);
    #1;
    rst_n = 1'b1;
    check_flag("mem_valid", 1'b0, mem_valid);
    check_flag("instr_valid", 1'b0, instr_valid);
    check_flag("lsu_done", 1'b0, lsu_done);
    check_flag("misaligned", 1'b0, misaligned);
    check_flag("busy", 1'b0, busy);

    test_name = "sequential fetch";
    fetch_enable = 1'b1;
    wait_fetches(16);

    test_name = "redirect";
    wait_fetches(1);
    pulse_redirect(32'h0000_0600);
    wait_fetches(6);
    repeat (2) @(posedge clock);
    pulse_redirect(32'h0000_0100);
    wait_fetches(8);
    #1;
    fetch_enable = 1'b0;
    wait_bus_idle();

    test_name = "load store";
    for (int k = 7; k >= 0; k--) begin
      run_op("sweep", lsu_op_t'(k), 32'h0000_0810, rand32()); // stores come first.
    end
    repeat (64) random_op();

    test_name = "misaligned";
    log_start = mem_model_i.log_count;
    run_op("lh odd", op_lh, 32'h0000_0809, '0);
    run_op("lhu odd", op_lhu, 32'h0000_080b, '0);
    run_op("lw half", op_lw, 32'h0000_080a, '0);
    run_op("sh odd", op_sh, 32'h0000_0809, rand32());
    run_op("sw half", op_sw, 32'h0000_080a, rand32());
    @(posedge clock);
    check_data("bus transfers", data_t'(log_start), data_t'(mem_model_i.log_count));
    run_op("lw after", op_lw, 32'h0000_0808, '0);

    test_name = "fetch with data";
    log_start   = mem_model_i.log_count;
    fetch_start = fetch_count;
    next_fetch  = expect_pc;
    track_bus   = 1'b1;
    @(posedge clock);
    #1;
    fetch_enable = 1'b1;
    repeat (60) random_op();
    @(posedge clock);
    #1;
    fetch_enable = 1'b0;
    wait_bus_idle();

    fetch_xfers = 0;
    for (int k = log_start; k < mem_model_i.log_count; k++) begin
      if (mem_model_i.log_instr[k]) begin
        check_addr("fetch transfer address", next_fetch, mem_model_i.log_addr[k]);
        check_strb("fetch transfer strobe", strb_none, mem_model_i.log_wstrb[k]);
        next_fetch = next_fetch + addr_t'(word_bytes);
        fetch_xfers++;
      end else begin
        if (xfer_addr_q.size() == 0) begin
          abort_run("a data transfer was logged with no lsu op behind it");
        end
        check_addr("data transfer address", xfer_addr_q.pop_front(), mem_model_i.log_addr[k]);
        check_strb("data transfer strobe", xfer_strb_q.pop_front(), mem_model_i.log_wstrb[k]);
      end
    end
    check_data("fetch transfers", data_t'(fetch_count - fetch_start), data_t'(fetch_xfers));
    check_data("missing data transfers", '0, data_t'(xfer_addr_q.size()));

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: sources.f
mem_bus_pkg.sv
lsu_pkg.sv
fetch_unit.sv
lsu.sv
mem_arbiter.sv
cpu_memory.sv
tb_mem_model.sv
tb_cpu_memory.sv

// File: run.sh
#!/bin/sh
# build and run the cpu_memory testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_cpu_memory -o tb_cpu_memory > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_cpu_memory > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

exit 0
